//--- tb.f
hw/cache_addr_pkg.sv
hw/mshr_pkg.sv
hw/mshr_sram_1rw.sv
hw/mshr.sv
hw/mshr_top.sv
tb/mshr_properties.sv
tb/tb_mshr.sv

//--- Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_mshr
FILELIST := tb.f
OBJ_DIR  := obj_dir
SIM      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(SIM) | tee $(LOG)
	@grep -q "^Test OK$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb/tb_mshr.sv
/* Table-driven testbench for the MSHR subsystem: clock, reset,
   stimulus table, result checks and cycle timeout */

`timescale 1ns/1ps

module tb_mshr;
    import cache_addr_pkg::*;
    import mshr_pkg::*;

    typedef enum logic [1:0] {OP_IDLE, OP_CHECK, OP_ALLOC, OP_ACK} op_e;

    // One table row, flags are {need_rsp, is_prefetch, wback}
    typedef struct {
        string       name;
        op_e         op;
        nline_u      nline;
        req_tid_t    req_id;
        req_sid_t    src_id;
        word_idx_t   word;
        cache_way_t  vway;
        logic [2:0]  flags;
        mshr_set_t   ack_set;
        mshr_way_t   ack_way;
        logic        exp_hit;
        logic        exp_afull;
        mshr_way_t   exp_way;
        logic        exp_empty;
        logic        exp_full;
        logic [27:0] exp_rec;
    } row_t;

    logic       clk_i;
    logic       rst_ni;
    logic       empty_o;
    logic       full_o;
    logic       check_i;
    nline_u     check_nline_i;
    logic       hit_o;
    logic       alloc_i;
    nline_u     alloc_nline_i;
    req_tid_t   alloc_req_id_i;
    req_sid_t   alloc_src_id_i;
    word_idx_t  alloc_word_i;
    cache_way_t alloc_victim_way_i;
    logic       alloc_need_rsp_i;
    logic       alloc_is_prefetch_i;
    logic       alloc_wback_i;
    logic       alloc_full_o;
    mshr_way_t  alloc_way_o;
    logic       ack_i;
    mshr_set_t  ack_set_i;
    mshr_way_t  ack_way_i;
    req_tid_t   ack_req_id_o;
    req_sid_t   ack_src_id_o;
    cache_set_t ack_cache_set_o;
    cache_tag_t ack_cache_tag_o;
    cache_way_t ack_cache_way_o;
    word_idx_t  ack_word_o;
    logic       ack_need_rsp_o;
    logic       ack_is_prefetch_o;
    logic       ack_wback_o;

    row_t        rows[$];
    int unsigned n_checks = 0;
    int unsigned n_errors = 0;
    int unsigned cycles = 0;
    int unsigned cycle_limit = 50;

    mshr_top dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    function automatic row_t blank_row(string name, op_e op, logic empty, logic full);
        row_t r;
        r.name      = name;
        r.op        = op;
        r.nline     = '0;
        r.req_id    = '0;
        r.src_id    = '0;
        r.word      = '0;
        r.vway      = '0;
        r.flags     = '0;
        r.ack_set   = '0;
        r.ack_way   = '0;
        r.exp_hit   = 1'b0;
        r.exp_afull = 1'b0;
        r.exp_way   = '0;
        r.exp_empty = empty;
        r.exp_full  = full;
        r.exp_rec   = '0;
        return r;
    endfunction

    function automatic void idle_row(string name, logic empty, logic full);
        rows.push_back(blank_row(name, OP_IDLE, empty, full));
    endfunction

    function automatic void probe_row(string name, cache_tag_t tag, cache_set_t set_idx,
                                      logic hit, logic afull, logic empty, logic full);
        row_t r;
        r = blank_row(name, OP_CHECK, empty, full);
        r.nline.fields.tag     = tag;
        r.nline.fields.set_idx = set_idx;
        r.exp_hit              = hit;
        r.exp_afull            = afull;
        rows.push_back(r);
    endfunction

    function automatic void alloc_row(string name, cache_tag_t tag, cache_set_t set_idx,
                                      req_tid_t req_id, req_sid_t src_id, word_idx_t word,
                                      cache_way_t vway, logic [2:0] flags, mshr_way_t way,
                                      logic empty, logic full);
        row_t r;
        r = blank_row(name, OP_ALLOC, empty, full);
        r.nline.fields.tag     = tag;
        r.nline.fields.set_idx = set_idx;
        r.req_id               = req_id;
        r.src_id               = src_id;
        r.word                 = word;
        r.vway                 = vway;
        r.flags                = flags;
        r.exp_way              = way;
        rows.push_back(r);
    endfunction

    function automatic void ack_row(string name, mshr_set_t mset, mshr_way_t way,
                                    req_tid_t req_id, req_sid_t src_id, cache_set_t set_idx,
                                    cache_tag_t tag, cache_way_t vway, word_idx_t word,
                                    logic [2:0] flags, logic empty, logic full);
        row_t r;
        r = blank_row(name, OP_ACK, empty, full);
        r.ack_set = mset;
        r.ack_way = way;
        r.exp_rec = {req_id, src_id, set_idx, tag, vway, word, flags};
        rows.push_back(r);
    endfunction

    task automatic build_table();
        idle_row("idle_after_reset", 1'b1, 1'b0);
        // probe: name, tag, cache set, hit, alloc_full, empty, full
        probe_row("check_reset", 8'h12, 6'h05, 1'b0, 1'b0, 1'b1, 1'b0);
        // alloc: name, tag, cache set, req, src, word, victim, flags, way, empty, full
        alloc_row("alloc_a", 8'h12, 6'h05, 4'h3, 2'h1, 3'h5, 2'h2, 3'b101, 1'b0, 1'b0, 1'b0);
        probe_row("check_same", 8'h12, 6'h05, 1'b1, 1'b0, 1'b0, 1'b0);
        probe_row("check_other_tag", 8'h34, 6'h05, 1'b0, 1'b0, 1'b0, 1'b0);
        probe_row("check_upper_set", 8'h12, 6'h25, 1'b0, 1'b0, 1'b0, 1'b0);
        alloc_row("alloc_b", 8'h34, 6'h25, 4'hA, 2'h2, 3'h1, 2'h1, 3'b010, 1'b1, 1'b0, 1'b0);
        probe_row("check_set1_full", 8'h56, 6'h09, 1'b0, 1'b1, 1'b0, 1'b0);
        probe_row("check_b_hit", 8'h34, 6'h25, 1'b1, 1'b1, 1'b0, 1'b0);
        // Two entries in each remaining MSHR set
        alloc_row("alloc_c", 8'h40, 6'h00, 4'h1, 2'h0, 3'h0, 2'h0, 3'b000, 1'b0, 1'b0, 1'b0);
        alloc_row("alloc_d", 8'h41, 6'h04, 4'h2, 2'h3, 3'h7, 2'h3, 3'b111, 1'b1, 1'b0, 1'b0);
        alloc_row("alloc_e", 8'h50, 6'h0A, 4'h4, 2'h1, 3'h2, 2'h1, 3'b001, 1'b0, 1'b0, 1'b0);
        alloc_row("alloc_f", 8'h51, 6'h3E, 4'h5, 2'h2, 3'h3, 2'h2, 3'b100, 1'b1, 1'b0, 1'b0);
        alloc_row("alloc_g", 8'h60, 6'h07, 4'h6, 2'h0, 3'h4, 2'h3, 3'b010, 1'b0, 1'b0, 1'b0);
        alloc_row("alloc_h", 8'h61, 6'h13, 4'h7, 2'h1, 3'h6, 2'h0, 3'b011, 1'b1, 1'b0, 1'b1);
        idle_row("idle_full", 1'b0, 1'b1);
        // ack: name, mshr set, way, expected req, src, cache set, tag, victim, word, flags
        ack_row("ack_a", 2'd1, 1'b0, 4'h3, 2'h1, 6'h05, 8'h12, 2'h2, 3'h5, 3'b101, 1'b0, 1'b0);
        probe_row("check_a_gone", 8'h12, 6'h05, 1'b0, 1'b0, 1'b0, 1'b0);
        probe_row("check_b_still", 8'h34, 6'h25, 1'b1, 1'b0, 1'b0, 1'b0);
        ack_row("ack_b", 2'd1, 1'b1, 4'hA, 2'h2, 6'h25, 8'h34, 2'h1, 3'h1, 3'b010, 1'b0, 1'b0);
        ack_row("ack_c", 2'd0, 1'b0, 4'h1, 2'h0, 6'h00, 8'h40, 2'h0, 3'h0, 3'b000, 1'b0, 1'b0);
        ack_row("ack_d", 2'd0, 1'b1, 4'h2, 2'h3, 6'h04, 8'h41, 2'h3, 3'h7, 3'b111, 1'b0, 1'b0);
        ack_row("ack_e", 2'd2, 1'b0, 4'h4, 2'h1, 6'h0A, 8'h50, 2'h1, 3'h2, 3'b001, 1'b0, 1'b0);
        ack_row("ack_f", 2'd2, 1'b1, 4'h5, 2'h2, 6'h3E, 8'h51, 2'h2, 3'h3, 3'b100, 1'b0, 1'b0);
        ack_row("ack_g", 2'd3, 1'b0, 4'h6, 2'h0, 6'h07, 8'h60, 2'h3, 3'h4, 3'b010, 1'b0, 1'b0);
        ack_row("ack_h", 2'd3, 1'b1, 4'h7, 2'h1, 6'h13, 8'h61, 2'h0, 3'h6, 3'b011, 1'b1, 1'b0);
        probe_row("check_empty", 8'h61, 6'h13, 1'b0, 1'b0, 1'b1, 1'b0);
    endtask

    task automatic compare_value(string name, string what,
                                 logic [31:0] expected, logic [31:0] actual);
        n_checks++;
        if (expected !== actual) begin
            n_errors++;
            $display("CHECK FAILED %s %s: expected %0h, actual %0h",
                     name, what, expected, actual);
        end
    endtask

    task automatic drive_row(row_t r);
        check_i             = (r.op == OP_CHECK);
        check_nline_i       = r.nline;
        alloc_i             = (r.op == OP_ALLOC);
        alloc_nline_i       = r.nline;
        alloc_req_id_i      = r.req_id;
        alloc_src_id_i      = r.src_id;
        alloc_word_i        = r.word;
        alloc_victim_way_i  = r.vway;
        alloc_need_rsp_i    = r.flags[2];
        alloc_is_prefetch_i = r.flags[1];
        alloc_wback_i       = r.flags[0];
        ack_i               = (r.op == OP_ACK);
        ack_set_i           = r.ack_set;
        ack_way_i           = r.ack_way;
    endtask

    // Results that appear one cycle after the operation
    task automatic verify_result(row_t r);
        if (r.op == OP_CHECK) begin
            compare_value(r.name, "hit_o", 32'(r.exp_hit), 32'(hit_o));
            compare_value(r.name, "alloc_full_o", 32'(r.exp_afull), 32'(alloc_full_o));
        end
        if (r.op == OP_ACK) begin
            compare_value(r.name, "ack record", 32'(r.exp_rec),
                          32'({ack_req_id_o, ack_src_id_o, ack_cache_set_o, ack_cache_tag_o,
                               ack_cache_way_o, ack_word_o, ack_need_rsp_o,
                               ack_is_prefetch_o, ack_wback_o}));
        end
        compare_value(r.name, "empty_o", 32'(r.exp_empty), 32'(empty_o));
        compare_value(r.name, "full_o", 32'(r.exp_full), 32'(full_o));
    endtask

    initial begin
        row_t idle;
        idle = blank_row("idle", OP_IDLE, 1'b1, 1'b0);
        rst_ni = 1'b0;
        drive_row(idle);
        build_table();
        cycle_limit = rows.size() * 4 + 50;
        repeat (2) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        for (int i = 0; i <= rows.size(); i++) begin
            @(posedge clk_i);
            #1;
            if (i < rows.size()) begin
                drive_row(rows[i]);
            end else begin
                drive_row(idle);
            end
            // Mid-cycle sampling point
            #4;
            if (i < rows.size() && rows[i].op == OP_ALLOC) begin
                compare_value(rows[i].name, "alloc_way_o", 32'(rows[i].exp_way),
                              32'(alloc_way_o));
            end
            if (i > 0) begin
                verify_result(rows[i-1]);
            end
        end
        $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Test FAILED");
            $finish;
        end
    end

endmodule

//--- tb/mshr_properties.sv
/* Protocol and state assertions for the MSHR, bound to mshr */

`timescale 1ns/1ps

module mshr_properties (
    input logic                   clk_i,
    input logic                   rst_ni,
    input logic                   check_i,
    input cache_addr_pkg::nline_u check_nline_i,
    input logic                   alloc_i,
    input cache_addr_pkg::nline_u alloc_nline_i,
    input logic                   ack_i,
    input logic                   alloc_full_o,
    input logic                   empty_o,
    input logic                   full_o
);
    import mshr_pkg::*;

    // Ack uses the memory port alone
    a_ack_alone: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ack_i |-> !(check_i || alloc_i))
        else $error("acknowledge issued together with check or allocate");

    a_empty_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(empty_o && full_o))
        else $error("empty and full are both high");

    // No allocation into a set that the last check found full
    a_alloc_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (check_i && !alloc_i) |=> !(alloc_i && alloc_full_o
            && (alloc_nline_i.fields.set_idx[MSHR_SET_W-1:0]
                == $past(check_nline_i.fields.set_idx[MSHR_SET_W-1:0]))))
        else $error("allocation into an MSHR set reported full");

endmodule

bind mshr mshr_properties u_props (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .check_i       (check_i),
    .check_nline_i (check_nline_i),
    .alloc_i       (alloc_i),
    .alloc_nline_i (alloc_nline_i),
    .ack_i         (ack_i),
    .alloc_full_o  (alloc_full_o),
    .empty_o       (empty_o),
    .full_o        (full_o)
);

//--- hw/mshr_top.sv
/* MSHR subsystem boundary around the MSHR instance */

`timescale 1ns/1ps

module mshr_top (
    input  logic                        clk_i,
    input  logic                        rst_ni,

    output logic                        empty_o,
    output logic                        full_o,

    input  logic                        check_i,
    input  cache_addr_pkg::nline_u      check_nline_i,
    output logic                        hit_o,

    input  logic                        alloc_i,
    input  cache_addr_pkg::nline_u      alloc_nline_i,
    input  cache_addr_pkg::req_tid_t    alloc_req_id_i,
    input  cache_addr_pkg::req_sid_t    alloc_src_id_i,
    input  cache_addr_pkg::word_idx_t   alloc_word_i,
    input  cache_addr_pkg::cache_way_t  alloc_victim_way_i,
    input  logic                        alloc_need_rsp_i,
    input  logic                        alloc_is_prefetch_i,
    input  logic                        alloc_wback_i,
    output logic                        alloc_full_o,
    output mshr_pkg::mshr_way_t         alloc_way_o,

    input  logic                        ack_i,
    input  mshr_pkg::mshr_set_t         ack_set_i,
    input  mshr_pkg::mshr_way_t         ack_way_i,
    output cache_addr_pkg::req_tid_t    ack_req_id_o,
    output cache_addr_pkg::req_sid_t    ack_src_id_o,
    output cache_addr_pkg::cache_set_t  ack_cache_set_o,
    output cache_addr_pkg::cache_tag_t  ack_cache_tag_o,
    output cache_addr_pkg::cache_way_t  ack_cache_way_o,
    output cache_addr_pkg::word_idx_t   ack_word_o,
    output logic                        ack_need_rsp_o,
    output logic                        ack_is_prefetch_o,
    output logic                        ack_wback_o
);

    mshr u_mshr (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .empty_o             (empty_o),
        .full_o              (full_o),
        .check_i             (check_i),
        .check_nline_i       (check_nline_i),
        .hit_o               (hit_o),
        .alloc_i             (alloc_i),
        .alloc_nline_i       (alloc_nline_i),
        .alloc_req_id_i      (alloc_req_id_i),
        .alloc_src_id_i      (alloc_src_id_i),
        .alloc_word_i        (alloc_word_i),
        .alloc_victim_way_i  (alloc_victim_way_i),
        .alloc_need_rsp_i    (alloc_need_rsp_i),
        .alloc_is_prefetch_i (alloc_is_prefetch_i),
        .alloc_wback_i       (alloc_wback_i),
        .alloc_full_o        (alloc_full_o),
        .alloc_way_o         (alloc_way_o),
        .ack_i               (ack_i),
        .ack_set_i           (ack_set_i),
        .ack_way_i           (ack_way_i),
        .ack_req_id_o        (ack_req_id_o),
        .ack_src_id_o        (ack_src_id_o),
        .ack_cache_set_o     (ack_cache_set_o),
        .ack_cache_tag_o     (ack_cache_tag_o),
        .ack_cache_way_o     (ack_cache_way_o),
        .ack_word_o          (ack_word_o),
        .ack_need_rsp_o      (ack_need_rsp_o),
        .ack_is_prefetch_o   (ack_is_prefetch_o),
        .ack_wback_o         (ack_wback_o)
    );

endmodule

//--- hw/mshr.sv
/* MSHR control: lowest free way search, hit detection on the
   registered check, valid and cache-set flops, entry memory */

`timescale 1ns/1ps

module mshr (
    input  logic                        clk_i,
    input  logic                        rst_ni,

    output logic                        empty_o,
    output logic                        full_o,

    // Check
    input  logic                        check_i,
    input  cache_addr_pkg::nline_u      check_nline_i,
    output logic                        hit_o,

    // Allocate
    input  logic                        alloc_i,
    input  cache_addr_pkg::nline_u      alloc_nline_i,
    input  cache_addr_pkg::req_tid_t    alloc_req_id_i,
    input  cache_addr_pkg::req_sid_t    alloc_src_id_i,
    input  cache_addr_pkg::word_idx_t   alloc_word_i,
    input  cache_addr_pkg::cache_way_t  alloc_victim_way_i,
    input  logic                        alloc_need_rsp_i,
    input  logic                        alloc_is_prefetch_i,
    input  logic                        alloc_wback_i,
    output logic                        alloc_full_o,
    output mshr_pkg::mshr_way_t         alloc_way_o,

    // Acknowledge
    input  logic                        ack_i,
    input  mshr_pkg::mshr_set_t         ack_set_i,
    input  mshr_pkg::mshr_way_t         ack_way_i,
    output cache_addr_pkg::req_tid_t    ack_req_id_o,
    output cache_addr_pkg::req_sid_t    ack_src_id_o,
    output cache_addr_pkg::cache_set_t  ack_cache_set_o,
    output cache_addr_pkg::cache_tag_t  ack_cache_tag_o,
    output cache_addr_pkg::cache_way_t  ack_cache_way_o,
    output cache_addr_pkg::word_idx_t   ack_word_o,
    output logic                        ack_need_rsp_o,
    output logic                        ack_is_prefetch_o,
    output logic                        ack_wback_o
);
    import cache_addr_pkg::*;
    import mshr_pkg::*;

    // Entry state, indexed [way][set]
    logic [MSHR_WAYS-1:0][MSHR_SETS-1:0] valid_q;
    logic [MSHR_ENTRIES-1:0]              valid_flat;
    cache_set_t                           cache_set_q [MSHR_WAYS][MSHR_SETS];

    // Check operation, registered for the compare in the next cycle
    logic       check_op;
    mshr_set_t  check_set;
    mshr_set_t  check_set_q;
    cache_set_t check_cache_set_q;
    cache_tag_t check_tag_q;
    logic [MSHR_WAYS-1:0] hit_way;

    mshr_set_t  alloc_set;
    mshr_way_t  ack_way_q;
    cache_set_t ack_cache_set_q;

    // Entry memory side
    logic                              mem_cs;
    mshr_set_t                         mem_addr;
    mshr_entry_t                       alloc_entry;
    logic [MSHR_WAYS*MSHR_ENTRY_W-1:0] mem_wmask;
    logic [MSHR_WAYS*MSHR_ENTRY_W-1:0] mem_wdata;
    logic [MSHR_WAYS*MSHR_ENTRY_W-1:0] mem_rdata;
    mshr_entry_t [MSHR_WAYS-1:0]       mem_rentry;

    // Allocation wins over a check in the same cycle
    assign check_op  = check_i & ~alloc_i;
    assign check_set = check_nline_i.fields.set_idx[MSHR_SET_W-1:0];
    assign alloc_set = alloc_nline_i.fields.set_idx[MSHR_SET_W-1:0];
    assign check_set_q = check_cache_set_q[MSHR_SET_W-1:0];

    // Lowest free way of the allocated set
    always_comb begin
        alloc_way_o = '0;
        for (int w = MSHR_WAYS - 1; w >= 0; w--) begin
            if (!valid_q[w][alloc_set]) begin
                alloc_way_o = mshr_way_t'(w);
            end
        end
    end

    // Full when no way of the checked set is free
    always_comb begin
        alloc_full_o = 1'b1;
        for (int w = 0; w < MSHR_WAYS; w++) begin
            if (!valid_q[w][check_set_q]) begin
                alloc_full_o = 1'b0;
            end
        end
    end

    // Hit needs the full cache set and the tag to match
    always_comb begin
        for (int w = 0; w < MSHR_WAYS; w++) begin
            hit_way[w] = valid_q[w][check_set_q]
                      && (cache_set_q[w][check_set_q] == check_cache_set_q)
                      && (mem_rentry[w].tag == check_tag_q);
        end
    end

    assign hit_o = |hit_way;

    assign valid_flat = valid_q;
    assign empty_o    = ~|valid_flat;
    assign full_o     = &valid_flat;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q           <= '0;
            check_cache_set_q <= '0;
            check_tag_q       <= '0;
            ack_way_q         <= '0;
        end else begin
            if (alloc_i) begin
                valid_q[alloc_way_o][alloc_set] <= 1'b1;
            end
            if (ack_i) begin
                valid_q[ack_way_i][ack_set_i] <= 1'b0;
                ack_way_q                     <= ack_way_i;
            end
            if (check_op) begin
                check_cache_set_q <= check_nline_i.fields.set_idx;
                check_tag_q       <= check_nline_i.fields.tag;
            end
        end
    end

    // Full cache set of each entry, and the one handed back on ack
    always_ff @(posedge clk_i) begin
        if (alloc_i) begin
            cache_set_q[alloc_way_o][alloc_set] <= alloc_nline_i.fields.set_idx;
        end
        if (ack_i) begin
            ack_cache_set_q <= cache_set_q[ack_way_i][ack_set_i];
        end
    end

    // Payload record for the allocated way
    always_comb begin
        alloc_entry.tag         = alloc_nline_i.fields.tag;
        alloc_entry.req_id      = alloc_req_id_i;
        alloc_entry.src_id      = alloc_src_id_i;
        alloc_entry.word_idx    = alloc_word_i;
        alloc_entry.victim_way  = alloc_victim_way_i;
        alloc_entry.wback       = alloc_wback_i;
        alloc_entry.need_rsp    = alloc_need_rsp_i;
        alloc_entry.is_prefetch = alloc_is_prefetch_i;
    end

    // Same record in every slice, mask picks the way
    assign mem_wdata = {MSHR_WAYS{alloc_entry}};

    always_comb begin
        for (int w = 0; w < MSHR_WAYS; w++) begin
            mem_wmask[w*MSHR_ENTRY_W +: MSHR_ENTRY_W] =
                {MSHR_ENTRY_W{alloc_way_o == mshr_way_t'(w)}};
        end
    end

    // Ack first, then alloc, then check
    assign mem_cs   = check_i | alloc_i | ack_i;
    assign mem_addr = ack_i ? ack_set_i : (alloc_i ? alloc_set : check_set);

    mshr_sram_1rw u_sram (
        .clk_i   (clk_i),
        .cs_i    (mem_cs),
        .we_i    (alloc_i),
        .addr_i  (mem_addr),
        .wmask_i (mem_wmask),
        .wdata_i (mem_wdata),
        .rdata_o (mem_rdata)
    );

    assign mem_rentry = mem_rdata;

    // Acknowledged record, one cycle after ack_i
    assign ack_req_id_o      = mem_rentry[ack_way_q].req_id;
    assign ack_src_id_o      = mem_rentry[ack_way_q].src_id;
    assign ack_cache_set_o   = ack_cache_set_q;
    assign ack_cache_tag_o   = mem_rentry[ack_way_q].tag;
    assign ack_cache_way_o   = mem_rentry[ack_way_q].victim_way;
    assign ack_word_o        = mem_rentry[ack_way_q].word_idx;
    assign ack_need_rsp_o    = mem_rentry[ack_way_q].need_rsp;
    assign ack_is_prefetch_o = mem_rentry[ack_way_q].is_prefetch;
    assign ack_wback_o       = mem_rentry[ack_way_q].wback;

endmodule

//--- hw/mshr_sram_1rw.sv
/* Single-port MSHR entry memory, one row per MSHR set,
   bit-masked write and registered read */

`timescale 1ns/1ps

module mshr_sram_1rw (
    input  logic                                                    clk_i,
    input  logic                                                    cs_i,
    input  logic                                                    we_i,
    input  mshr_pkg::mshr_set_t                                     addr_i,
    input  logic [mshr_pkg::MSHR_WAYS*mshr_pkg::MSHR_ENTRY_W-1:0]   wmask_i,
    input  logic [mshr_pkg::MSHR_WAYS*mshr_pkg::MSHR_ENTRY_W-1:0]   wdata_i,
    output logic [mshr_pkg::MSHR_WAYS*mshr_pkg::MSHR_ENTRY_W-1:0]   rdata_o
);
    import mshr_pkg::*;

    logic [MSHR_WAYS*MSHR_ENTRY_W-1:0] mem_q [MSHR_SETS];

    // Write keeps unmasked bits, read returns the row before the write
    always_ff @(posedge clk_i) begin
        if (cs_i) begin
            if (we_i) begin
                mem_q[addr_i] <= (mem_q[addr_i] & ~wmask_i) | (wdata_i & wmask_i);
            end
            rdata_o <= mem_q[addr_i];
        end
    end

endmodule

//--- hw/mshr_pkg.sv
/* MSHR organization: sets, ways, index types and the entry record */

package mshr_pkg;

    // 4 sets of 2 ways, 8 outstanding misses
    localparam int unsigned MSHR_SETS    = 4;
    localparam int unsigned MSHR_WAYS    = 2;
    localparam int unsigned MSHR_SET_W   = $clog2(MSHR_SETS);
    localparam int unsigned MSHR_WAY_W   = $clog2(MSHR_WAYS);
    localparam int unsigned MSHR_ENTRIES = MSHR_SETS * MSHR_WAYS;

    // MSHR set is the low MSHR_SET_W bits of the cache set
    typedef logic [MSHR_SET_W-1:0] mshr_set_t;
    typedef logic [MSHR_WAY_W-1:0] mshr_way_t;

    // Record stored per outstanding miss. The cache set itself
    // lives in flops next to the valid bits
    typedef struct packed {
        cache_addr_pkg::cache_tag_t tag;
        cache_addr_pkg::req_tid_t   req_id;
        cache_addr_pkg::req_sid_t   src_id;
        cache_addr_pkg::word_idx_t  word_idx;
        cache_addr_pkg::cache_way_t victim_way;
        logic                       wback;
        logic                       need_rsp;
        logic                       is_prefetch;
    } mshr_entry_t;

    // One memory row holds MSHR_WAYS entries side by side
    localparam int unsigned MSHR_ENTRY_W = $bits(mshr_entry_t);

endpackage

//--- hw/cache_addr_pkg.sv
/* Cache address geometry: set, tag, way and word widths,
   requester id types and the line number union */

package cache_addr_pkg;

    // Line number is tag above set
    localparam int unsigned CACHE_SET_W = 6;
    localparam int unsigned CACHE_TAG_W = 8;
    localparam int unsigned NLINE_W     = CACHE_TAG_W + CACHE_SET_W;

    // 4-way cache, 8 words per line
    localparam int unsigned CACHE_WAY_W = 2;
    localparam int unsigned WORD_W      = 3;

    // Requester identifiers
    localparam int unsigned REQ_TID_W = 4;
    localparam int unsigned REQ_SID_W = 2;

    typedef logic [CACHE_SET_W-1:0] cache_set_t;
    typedef logic [CACHE_TAG_W-1:0] cache_tag_t;
    typedef logic [CACHE_WAY_W-1:0] cache_way_t;
    typedef logic [WORD_W-1:0]      word_idx_t;
    typedef logic [REQ_TID_W-1:0]   req_tid_t;
    typedef logic [REQ_SID_W-1:0]   req_sid_t;

    // Split view of a line number
    typedef struct packed {
        cache_tag_t tag;
        cache_set_t set_idx;
    } nline_fields_t;

    // Same 14 bits, seen whole or as tag and set
    typedef union packed {
        logic [NLINE_W-1:0] raw;
        nline_fields_t      fields;
    } nline_u;

endpackage
